// ==== hdl/mapper_params.svh ====
`ifndef MAPPER_PARAMS_SVH
`define MAPPER_PARAMS_SVH

// architectural register file seen by software
`define MAPPER_ARCH_REGS 32

// physical registers behind the rename map
`define MAPPER_PHYS_REGS 64

// physical tag width, log2 of the physical register count
`define MAPPER_TAG_W 6

// reorder buffer index width, 128 entries
`define MAPPER_ROB_W 7

`endif

// ==== hdl/mapper_pkg.sv ====
`include "mapper_params.svh"

package mapper_pkg;

    // arch register index width
    localparam int ARCH_W = $clog2(`MAPPER_ARCH_REGS);

    // tags beyond the identity mapping start out free
    localparam int FL_DEPTH = `MAPPER_PHYS_REGS - `MAPPER_ARCH_REGS;

    // register form, form bit clear
    typedef struct packed {
        logic              form;
        logic [5:0]        opcode;
        logic [ARCH_W-1:0] dest;
        logic [ARCH_W-1:0] src1;
        logic [ARCH_W-1:0] src2;
        logic [9:0]        unused;
    } mapper_rform_t;

    // immediate form, form bit set
    typedef struct packed {
        logic              form;
        logic [5:0]        opcode;
        logic [ARCH_W-1:0] dest;
        logic [ARCH_W-1:0] src1;
        logic [14:0]       imm;
    } mapper_iform_t;

    // form bit picks the view, top bits shared
    typedef union packed {
        mapper_rform_t r;
        mapper_iform_t i;
    } mapper_insn_u;

endpackage

// ==== hdl/src_lookup.sv ====
`timescale 1ns/1ps

`include "mapper_params.svh"

module src_lookup
    import mapper_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  mapper_insn_u             insn,
    input  logic                     rename_fire,
    input  logic [`MAPPER_TAG_W-1:0] new_tag,
    input  logic                     wb_valid,
    input  logic [`MAPPER_TAG_W-1:0] wb_tag,
    output logic [`MAPPER_TAG_W-1:0] src1_tag,
    output logic                     src1_rdy,
    output logic [`MAPPER_TAG_W-1:0] src2_tag,
    output logic                     src2_rdy,
    output logic [`MAPPER_TAG_W-1:0] old_tag
);

    localparam int TAG_W = `MAPPER_TAG_W;

    // speculative alias table, arch reg -> phys tag
    logic [TAG_W-1:0] alias_tab [`MAPPER_ARCH_REGS];

    // one bit per physical register, set once the value exists
    logic [`MAPPER_PHYS_REGS-1:0] ready_tab;

    logic reg_form;
    logic src1_wb_hit;
    logic src2_wb_hit;

    assign reg_form = ~insn.r.form;

    // source lookups, purely combinational
    assign src1_tag = alias_tab[insn.r.src1];
    assign src2_tag = reg_form ? alias_tab[insn.r.src2] : '0; // no src2 for imm form
    assign old_tag  = alias_tab[insn.r.dest];                 // dest sits in both views

    // writeback landing this cycle counts as ready
    assign src1_wb_hit = wb_valid && (wb_tag == src1_tag);
    assign src2_wb_hit = wb_valid && (wb_tag == src2_tag);

    assign src1_rdy = ready_tab[src1_tag] | src1_wb_hit;
    assign src2_rdy = reg_form & (ready_tab[src2_tag] | src2_wb_hit);

    // alias table update
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MAPPER_ARCH_REGS; i++) begin
                alias_tab[i] <= TAG_W'(i); // identity map
            end
        end else if (rename_fire) begin
            alias_tab[insn.r.dest] <= new_tag;
        end
    end

    // ready table update
    always_ff @(posedge clk) begin
        if (reset) begin
            ready_tab <= '1;
        end else begin
            if (wb_valid) begin
                ready_tab[wb_tag] <= 1'b1;
            end
            // fresh destination has no value yet, wins over a stale writeback
            if (rename_fire) begin
                ready_tab[new_tag] <= 1'b0;
            end
        end
    end

endmodule

// ==== hdl/dest_alloc.sv ====
`timescale 1ns/1ps

`include "mapper_params.svh"

module dest_alloc
    import mapper_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     rename_fire,
    input  logic                     free_valid,
    input  logic [`MAPPER_TAG_W-1:0] free_tag,
    output logic [`MAPPER_TAG_W-1:0] new_tag,
    output logic                     fl_empty
);

    localparam int TAG_W = `MAPPER_TAG_W;
    localparam int PTR_W = $clog2(FL_DEPTH);

    logic [TAG_W-1:0] fl_mem [FL_DEPTH];
    logic [PTR_W-1:0] head;  // next tag handed out
    logic [PTR_W-1:0] tail;  // next slot for a returned tag
    logic [PTR_W:0]   count; // 0 .. FL_DEPTH

    assign new_tag  = fl_mem[head];
    assign fl_empty = (count == '0);

    // queue storage, preloaded with the tags above the identity map
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                fl_mem[i] <= TAG_W'(`MAPPER_ARCH_REGS + i);
            end
        end else if (free_valid) begin
            fl_mem[tail] <= free_tag;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0; // full queue, tail meets head
            count <= (PTR_W + 1)'(FL_DEPTH);
        end else begin
            if (rename_fire) begin
                head <= head + 1'b1;
            end
            if (free_valid) begin
                tail <= tail + 1'b1;
            end
            case ({free_valid, rename_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // push and pop cancel
            endcase
        end
    end

endmodule

// ==== hdl/dispatch.sv ====
`timescale 1ns/1ps

`include "mapper_params.svh"

module dispatch
    import mapper_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     insn_valid,
    input  mapper_insn_u             insn,
    input  logic [31:0]              pc,
    input  logic                     except_in,
    input  logic                     rob_full,
    input  logic [`MAPPER_ROB_W-1:0] rob_entry_in,
    input  logic [`MAPPER_TAG_W-1:0] src1_tag,
    input  logic                     src1_rdy,
    input  logic [`MAPPER_TAG_W-1:0] src2_tag,
    input  logic                     src2_rdy,
    input  logic [`MAPPER_TAG_W-1:0] old_tag,
    input  logic [`MAPPER_TAG_W-1:0] new_tag,
    input  logic                     fl_empty,
    output logic                     rename_fire,
    output logic                     stall,
    output logic                     alloc_rob,
    output logic [5:0]               uop_out,
    output logic [`MAPPER_TAG_W-1:0] op1_tag,
    output logic                     op1_rdy,
    output logic [`MAPPER_TAG_W-1:0] op2_tag,
    output logic                     op2_rdy,
    output logic [14:0]              op2_imm,
    output logic                     use_imm,
    output logic [ARCH_W-1:0]        dest_arch,
    output logic [`MAPPER_TAG_W-1:0] dest_tag,
    output logic [`MAPPER_TAG_W-1:0] dest_oldtag,
    output logic [31:0]              pc_out,
    output logic [`MAPPER_ROB_W-1:0] rob_entry_out,
    output logic                     except_out
);

    logic imm_form;

    // accept only with room in the rob and a free tag
    assign rename_fire = insn_valid & ~rob_full & ~fl_empty;
    assign stall       = insn_valid & ~rename_fire;

    assign imm_form = insn.i.form;

    always_ff @(posedge clk) begin
        if (reset) begin
            alloc_rob <= 1'b0;
        end else begin
            alloc_rob <= rename_fire; // one pulse per accepted insn
        end
    end

    // packet toward rs and rob, holds while nothing fires
    always_ff @(posedge clk) begin
        if (rename_fire) begin
            uop_out       <= insn.r.opcode;
            op1_tag       <= src1_tag;
            op1_rdy       <= src1_rdy;
            op2_tag       <= imm_form ? '0 : src2_tag;
            op2_rdy       <= imm_form | src2_rdy;      // immediate is always there
            op2_imm       <= imm_form ? insn.i.imm : '0;
            use_imm       <= imm_form;
            dest_arch     <= insn.r.dest;
            dest_tag      <= new_tag;
            dest_oldtag   <= old_tag;                   // freed at commit
            pc_out        <= pc;
            rob_entry_out <= rob_entry_in;
            except_out    <= except_in;
        end
    end

endmodule

// ==== hdl/mapper_top.sv ====
`timescale 1ns/1ps

`include "mapper_params.svh"

module mapper_top
    import mapper_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     insn_valid,
    input  mapper_insn_u             insn,
    input  logic [31:0]              pc,
    input  logic                     except_in,
    input  logic                     rob_full,
    input  logic [`MAPPER_ROB_W-1:0] rob_entry_in,
    input  logic                     wb_valid,
    input  logic [`MAPPER_TAG_W-1:0] wb_tag,
    input  logic                     free_valid,
    input  logic [`MAPPER_TAG_W-1:0] free_tag,
    output logic                     stall,
    output logic                     alloc_rob,
    output logic [5:0]               uop_out,
    output logic [`MAPPER_TAG_W-1:0] op1_tag,
    output logic                     op1_rdy,
    output logic [`MAPPER_TAG_W-1:0] op2_tag,
    output logic                     op2_rdy,
    output logic [14:0]              op2_imm,
    output logic                     use_imm,
    output logic [ARCH_W-1:0]        dest_arch,
    output logic [`MAPPER_TAG_W-1:0] dest_tag,
    output logic [`MAPPER_TAG_W-1:0] dest_oldtag,
    output logic [31:0]              pc_out,
    output logic [`MAPPER_ROB_W-1:0] rob_entry_out,
    output logic                     except_out
);

    logic [`MAPPER_TAG_W-1:0] src1_tag;
    logic                     src1_rdy;
    logic [`MAPPER_TAG_W-1:0] src2_tag;
    logic                     src2_rdy;
    logic [`MAPPER_TAG_W-1:0] old_tag;
    logic [`MAPPER_TAG_W-1:0] new_tag;
    logic                     fl_empty;
    logic                     rename_fire; // single accept pulse to both sides

    // source side
    src_lookup i_src_lookup (
        .clk         (clk),
        .reset       (reset),
        .insn        (insn),
        .rename_fire (rename_fire),
        .new_tag     (new_tag),
        .wb_valid    (wb_valid),
        .wb_tag      (wb_tag),
        .src1_tag    (src1_tag),
        .src1_rdy    (src1_rdy),
        .src2_tag    (src2_tag),
        .src2_rdy    (src2_rdy),
        .old_tag     (old_tag)
    );

    // destination side
    dest_alloc i_dest_alloc (
        .clk         (clk),
        .reset       (reset),
        .rename_fire (rename_fire),
        .free_valid  (free_valid),
        .free_tag    (free_tag),
        .new_tag     (new_tag),
        .fl_empty    (fl_empty)
    );

    dispatch i_dispatch (
        .clk           (clk),
        .reset         (reset),
        .insn_valid    (insn_valid),
        .insn          (insn),
        .pc            (pc),
        .except_in     (except_in),
        .rob_full      (rob_full),
        .rob_entry_in  (rob_entry_in),
        .src1_tag      (src1_tag),
        .src1_rdy      (src1_rdy),
        .src2_tag      (src2_tag),
        .src2_rdy      (src2_rdy),
        .old_tag       (old_tag),
        .new_tag       (new_tag),
        .fl_empty      (fl_empty),
        .rename_fire   (rename_fire),
        .stall         (stall),
        .alloc_rob     (alloc_rob),
        .uop_out       (uop_out),
        .op1_tag       (op1_tag),
        .op1_rdy       (op1_rdy),
        .op2_tag       (op2_tag),
        .op2_rdy       (op2_rdy),
        .op2_imm       (op2_imm),
        .use_imm       (use_imm),
        .dest_arch     (dest_arch),
        .dest_tag      (dest_tag),
        .dest_oldtag   (dest_oldtag),
        .pc_out        (pc_out),
        .rob_entry_out (rob_entry_out),
        .except_out    (except_out)
    );

endmodule

// ==== dv/mapper_asserts.sv ====
`timescale 1ns/1ps

`include "mapper_params.svh"

module mapper_asserts
    import mapper_pkg::*;
(
    input logic                     clk,
    input logic                     reset,
    input mapper_insn_u             insn,
    input logic                     rob_full,
    input logic                     fl_empty,
    input logic                     stall,
    input logic                     rename_fire,
    input logic                     alloc_rob,
    input logic [`MAPPER_TAG_W-1:0] dest_tag
);

    // a full rob blocks the allocation one cycle later
    a_full_blocks_alloc: assert property (
        @(posedge clk) disable iff (reset) $past(rob_full) |-> !alloc_rob
    ) else $error("alloc_rob after a cycle with rob_full high");

    // upstream keeps a stalled insn in place until it is taken
    a_stall_holds_insn: assert property (
        @(posedge clk) disable iff (reset) stall |=> $stable(insn)
    ) else $error("insn changed right after a stalled cycle");

    // upper tags only come out of a non-empty free list
    a_tag_from_list: assert property (
        @(posedge clk) disable iff (reset)
        alloc_rob && dest_tag >= `MAPPER_ARCH_REGS |-> $past(!fl_empty)
    ) else $error("dest_tag %0d dispatched from an empty free list", dest_tag);

endmodule

bind dispatch mapper_asserts i_asserts (.*);

// ==== dv/mapper_tb.sv ====
`timescale 1ns/1ps

`include "mapper_params.svh"

module mapper_tb
    import mapper_pkg::*;
();

    logic clk, reset, insn_valid, except_in, rob_full, wb_valid, free_valid;
    logic stall, alloc_rob, op1_rdy, op2_rdy, use_imm, except_out;
    mapper_insn_u insn;
    logic [31:0] pc, pc_out;
    logic [`MAPPER_ROB_W-1:0] rob_entry_in, rob_entry_out;
    logic [`MAPPER_TAG_W-1:0] wb_tag, free_tag, op1_tag, op2_tag, dest_tag, dest_oldtag;
    logic [5:0] uop_out;
    logic [14:0] op2_imm;
    logic [ARCH_W-1:0] dest_arch;

    // reference model of map, ready bits and free list
    logic [`MAPPER_TAG_W-1:0] ref_alias [`MAPPER_ARCH_REGS];
    logic ref_ready [`MAPPER_PHYS_REGS];
    logic [`MAPPER_TAG_W-1:0] ref_free [$];
    logic [`MAPPER_TAG_W-1:0] ref_retired [$]; // old tags in dispatch order
    int seed = 14;
    int mismatches = 0;
    int timeouts = 0;

    mapper_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic compare(string what, logic [63:0] got, logic [63:0] want);
        if (got !== want) begin
            mismatches++;
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    // drive an insn with fresh side fields, expect it to stall for a while
    task automatic present_insn(mapper_insn_u ins, int stall_cycles);
        insn_valid   = 1'b1;
        insn         = ins;
        pc           = $random(seed);
        rob_entry_in = $random(seed);
        except_in    = $random(seed);
        repeat (stall_cycles) begin
            #1;
            compare("stall", stall, 1'b1);
            @(posedge clk);
            #5;
            compare("alloc_rob under stall", alloc_rob, 1'b0);
        end
    endtask

    // hold the insn until dispatch takes it, then check the packet against the model
    task automatic dispatch_insn(mapper_insn_u ins);
        logic [`MAPPER_TAG_W-1:0] s1, s2, old_t;
        logic imm, r1, r2;
        int waited = 0;
        if (!insn_valid || insn !== ins) begin
            present_insn(ins, 0);
        end
        imm   = ins.i.form;
        s1    = ref_alias[ins.r.src1];
        s2    = imm ? '0 : ref_alias[ins.r.src2];
        r1    = ref_ready[s1] || (wb_valid && wb_tag == s1); // same-cycle writeback
        r2    = imm || ref_ready[s2] || (wb_valid && wb_tag == s2);
        old_t = ref_alias[ins.r.dest];
        do begin
            @(posedge clk);
            #5;
            waited++;
        end while (!alloc_rob && waited < 40);
        insn_valid = 1'b0;
        if (!alloc_rob) begin
            timeouts++;
            $display("alloc_rob did not rise within 40 cycles, gave up at %0t", $time);
        end else begin
            compare("opcode/op1", {uop_out, op1_tag, op1_rdy}, {ins.r.opcode, s1, r1});
            compare("op2", {op2_tag, op2_rdy, use_imm}, {s2, r2, imm});
            compare("dest", {dest_arch, dest_tag, dest_oldtag},
                    {ins.r.dest, ref_free[0], old_t});
            compare("passthru", {pc_out, rob_entry_out, except_out},
                    {pc, rob_entry_in, except_in});
            if (imm) begin
                compare("op2_imm", op2_imm, ins.i.imm);
            end
            if (wb_valid) begin
                ref_ready[wb_tag] = 1'b1;
            end
            ref_alias[ins.r.dest] = ref_free.pop_front();
            ref_ready[ref_alias[ins.r.dest]] = 1'b0; // new tag has no value yet
            ref_retired.push_back(old_t);
        end
        wb_valid = 1'b0;
    endtask

    // commit hands an old tag back
    task automatic return_tag(logic [`MAPPER_TAG_W-1:0] t);
        free_valid = 1'b1;
        free_tag   = t;
        ref_free.push_back(t);
        @(posedge clk);
        #5;
        free_valid = 1'b0;
    endtask

    task automatic identity_lookup();
        dispatch_insn({1'b0, 6'h01, 5'd3, 5'd1, 5'd2, 10'h0}); // r3 <- r1, r2
    endtask

    // r3 now lives in tag 32, not ready until its writeback
    task automatic dependency_chain();
        dispatch_insn({1'b0, 6'h02, 5'd4, 5'd3, 5'd5, 10'h0});
        wb_valid = 1'b1;
        wb_tag   = ref_alias[3];
        dispatch_insn({1'b0, 6'h03, 5'd6, 5'd3, 5'd3, 10'h0}); // through the bypass
        dispatch_insn({1'b0, 6'h04, 5'd7, 5'd3, 5'd4, 10'h0}); // from the table
    endtask

    task automatic immediate_operand();
        dispatch_insn({1'b1, 6'h10, 5'd8, 5'd4, 15'h5a3c});
    endtask

    task automatic rob_backpressure();
        rob_full = 1'b1;
        present_insn({1'b0, 6'h05, 5'd9, 5'd8, 5'd1, 10'h0}, 3);
        rob_full = 1'b0;
        dispatch_insn(insn); // held insn still gets the untouched head tag
    endtask

    // drain the free list, then hand single tags back in commit order
    task automatic free_list_drain();
        repeat (ref_free.size()) begin
            dispatch_insn($random(seed));
        end
        present_insn($random(seed), 4);
        return_tag(ref_retired.pop_front());
        dispatch_insn(insn);
        repeat (3) begin
            return_tag(ref_retired.pop_front());
        end
        repeat (3) begin
            dispatch_insn($random(seed));
        end
    endtask

    initial begin
        reset = 1'b1;
        {insn_valid, except_in, rob_full, wb_valid, free_valid} = '0;
        {pc, rob_entry_in, wb_tag, free_tag} = '0;
        insn = '0;
        for (int i = 0; i < `MAPPER_PHYS_REGS; i++) begin
            ref_ready[i] = 1'b1;
            if (i < `MAPPER_ARCH_REGS) begin
                ref_alias[i] = i; // identity map
            end else begin
                ref_free.push_back(i);
            end
        end
        repeat (8) @(posedge clk);
        #5;
        reset = 1'b0;
        compare("alloc_rob and stall after reset", {alloc_rob, stall}, 2'b00);
        identity_lookup();
        dependency_chain();
        immediate_operand();
        rob_backpressure();
        free_list_drain();
        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches + timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+hdl
hdl/mapper_pkg.sv
hdl/src_lookup.sv
hdl/dest_alloc.sv
hdl/dispatch.sv
hdl/mapper_top.sv
dv/mapper_asserts.sv
dv/mapper_tb.sv

// ==== Bender.yml ====
package:
  name: mapper

export_include_dirs:
  - hdl

sources:
  - hdl/mapper_pkg.sv
  - hdl/src_lookup.sv
  - hdl/dest_alloc.sv
  - hdl/dispatch.sv
  - hdl/mapper_top.sv
  - target: test
    files:
      - dv/mapper_asserts.sv
      - dv/mapper_tb.sv
